//--- bridge_settings.svh
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// Mesh coordinate width, per axis.
`define COORD_W 2

// Position of this bridge in the mesh.
`define NODE_X 1
`define NODE_Y 2

`define REQ_FIFO_DEPTH 4 // Outgoing request flits.
`define RSP_FIFO_DEPTH 2 // Incoming response flits.

`endif

//--- axi_pkg.sv
package axi_pkg;

    typedef logic [3:0]  axi_id_t;
    typedef logic [15:0] axi_addr_t;
    typedef logic [7:0]  axi_len_t; // Beats minus one.
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;

    // Only 4-byte INCR bursts are handled.
    localparam logic [2:0] AXI_SIZE_4B    = 3'd2;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    localparam int ADDR_MSB = $bits(axi_addr_t) - 1;

endpackage

//--- noc_pkg.sv
`include "bridge_settings.svh"

package noc_pkg;

    import axi_pkg::*;

    typedef logic [39:0]         flit_t;
    typedef logic [`COORD_W-1:0] coord_t;

    typedef enum logic [1:0] {
        KIND_HEAD   = 2'd0,
        KIND_BODY   = 2'd1,
        KIND_TAIL   = 2'd2,
        KIND_SINGLE = 2'd3
    } flit_kind_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } noc_op_e;

    // Request head. Destination comes from the top address bits.
    function automatic flit_t head_flit(flit_kind_e kind, noc_op_e op, axi_id_t id,
                                        axi_len_t len, axi_addr_t addr);
        coord_t dst_x;
        coord_t dst_y;
        dst_x = addr[ADDR_MSB -: `COORD_W];
        dst_y = addr[ADDR_MSB - `COORD_W -: `COORD_W];
        return {kind, op, dst_x, dst_y, coord_t'(`NODE_X), coord_t'(`NODE_Y),
                id, len, addr, 1'b0};
    endfunction

    function automatic flit_t data_flit(flit_kind_e kind, axi_strb_t strb, axi_data_t data);
        return {kind, strb, data, 2'b00};
    endfunction

    function automatic flit_t rsp_flit(flit_kind_e kind, noc_op_e op, axi_id_t id,
                                       axi_data_t data);
        return {kind, op, id, data, 1'b0};
    endfunction

    // Kind sits on top in every layout.
    function automatic flit_kind_e flit_kind(flit_t f);
        return flit_kind_e'(f[39:38]);
    endfunction

    function automatic noc_op_e flit_op(flit_t f);
        return noc_op_e'(f[37]);
    endfunction

endpackage

//--- flit_fifo.sv
`timescale 1ns/100ps

module flit_fifo #(
    parameter int DEPTH = 4
) (
    input  logic            aclk,
    input  logic            arst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  noc_pkg::flit_t  in_flit,
    output logic            out_valid,
    input  logic            out_ready,
    output noc_pkg::flit_t  out_flit
);

    import noc_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    flit_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_flit  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge aclk) begin
        if (push) mem[wr_ptr] <= in_flit;
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither.
            endcase
        end
    end

    a_count_bound: assert property (@(posedge aclk) disable iff (!arst_n)
        count <= CNT_W'(DEPTH))
        else $error("flit_fifo: count above DEPTH");

endmodule

//--- axi_req_packetizer.sv
`timescale 1ns/100ps
`include "bridge_settings.svh"

module axi_req_packetizer (
    input  logic               aclk,
    input  logic               arst_n,

    input  logic               awvalid,
    output logic               awready,
    input  axi_pkg::axi_id_t   awid,
    input  axi_pkg::axi_addr_t awaddr,
    input  axi_pkg::axi_len_t  awlen,
    input  logic [2:0]         awsize,
    input  logic [1:0]         awburst,

    input  logic               wvalid,
    output logic               wready,
    input  axi_pkg::axi_data_t wdata,
    input  axi_pkg::axi_strb_t wstrb,
    input  logic               wlast,

    input  logic               arvalid,
    output logic               arready,
    input  axi_pkg::axi_id_t   arid,
    input  axi_pkg::axi_addr_t araddr,
    input  axi_pkg::axi_len_t  arlen,
    input  logic [2:0]         arsize,
    input  logic [1:0]         arburst,

    output logic               req_valid,
    input  logic               req_ready,
    output noc_pkg::flit_t     req_flit
);

    import axi_pkg::*;
    import noc_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WR_HEAD,
        ST_WR_DATA,
        ST_RD_HEAD
    } state_e;

    state_e    state;
    logic      last_grant_rd; // Set when AR won the last grant.
    logic      grant_aw;
    logic      grant_ar;
    logic      last_beat;
    axi_len_t  beat_cnt;
    axi_id_t   id_q;
    axi_addr_t addr_q;
    axi_len_t  len_q;

    // Round robin between AW and AR, only with room downstream.
    always_comb begin
        grant_aw = 1'b0;
        grant_ar = 1'b0;
        if (state == ST_IDLE && req_ready) begin
            if (awvalid && arvalid) begin
                grant_aw = last_grant_rd;
                grant_ar = !last_grant_rd;
            end else begin
                grant_aw = awvalid;
                grant_ar = arvalid;
            end
        end
    end

    assign awready   = grant_aw;
    assign arready   = grant_ar;
    assign wready    = (state == ST_WR_DATA) && req_ready;
    assign last_beat = (beat_cnt == len_q);

    always_comb begin
        req_valid = 1'b0;
        req_flit  = '0;
        case (state)
            ST_WR_HEAD: begin
                req_valid = 1'b1;
                req_flit  = head_flit(KIND_HEAD, OP_WRITE, id_q, len_q, addr_q);
            end
            ST_WR_DATA: begin
                req_valid = wvalid; // W beat goes straight through.
                req_flit  = data_flit(last_beat ? KIND_TAIL : KIND_BODY, wstrb, wdata);
            end
            ST_RD_HEAD: begin
                req_valid = 1'b1;
                req_flit  = head_flit(KIND_SINGLE, OP_READ, id_q, len_q, addr_q);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= ST_IDLE;
            last_grant_rd <= 1'b1;
            beat_cnt      <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (grant_aw) begin
                        state         <= ST_WR_HEAD;
                        last_grant_rd <= 1'b0;
                    end else if (grant_ar) begin
                        state         <= ST_RD_HEAD;
                        last_grant_rd <= 1'b1;
                    end
                end
                ST_WR_HEAD: begin
                    if (req_ready) begin
                        state    <= ST_WR_DATA;
                        beat_cnt <= '0;
                    end
                end
                ST_WR_DATA: begin
                    if (wvalid && req_ready) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) state <= ST_IDLE;
                    end
                end
                ST_RD_HEAD: begin
                    if (req_ready) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address fields of the granted request.
    always_ff @(posedge aclk) begin
        if (grant_aw) begin
            id_q   <= awid;
            addr_q <= awaddr;
            len_q  <= awlen;
        end else if (grant_ar) begin
            id_q   <= arid;
            addr_q <= araddr;
            len_q  <= arlen;
        end
    end

    a_aw_incr4: assert property (@(posedge aclk) disable iff (!arst_n)
        awvalid && awready |-> awsize == AXI_SIZE_4B && awburst == AXI_BURST_INCR)
        else $error("packetizer: unsupported AW size or burst");

    a_ar_incr4: assert property (@(posedge aclk) disable iff (!arst_n)
        arvalid && arready |-> arsize == AXI_SIZE_4B && arburst == AXI_BURST_INCR)
        else $error("packetizer: unsupported AR size or burst");

    a_wlast_count: assert property (@(posedge aclk) disable iff (!arst_n)
        wvalid && wready |-> wlast == last_beat)
        else $error("packetizer: wlast does not match awlen");

endmodule

//--- axi_resp_depacketizer.sv
`timescale 1ns/100ps

module axi_resp_depacketizer (
    input  logic               aclk,
    input  logic               arst_n,

    input  logic               rsp_valid,
    output logic               rsp_ready,
    input  noc_pkg::flit_t     rsp_flit,

    output logic               bvalid,
    output axi_pkg::axi_id_t   bid,
    input  logic               bready,

    output logic               rvalid,
    output axi_pkg::axi_id_t   rid,
    output axi_pkg::axi_data_t rdata,
    output logic               rlast,
    input  logic               rready
);

    import axi_pkg::*;
    import noc_pkg::*;

    flit_kind_e kind;
    noc_op_e    op;
    axi_id_t    flit_id;
    axi_data_t  flit_data;
    logic       b_free;
    logic       r_free;
    logic       take;
    logic       load_b;
    logic       load_r;

    // Response layout is kind, op, id, data, spare.
    assign kind      = flit_kind(rsp_flit);
    assign op        = flit_op(rsp_flit);
    assign flit_id   = rsp_flit[36:33];
    assign flit_data = rsp_flit[32:1];

    // A register is free when empty or draining this cycle.
    assign b_free = !bvalid || bready;
    assign r_free = !rvalid || rready;

    assign rsp_ready = (op == OP_WRITE) ? b_free : r_free;

    assign take   = rsp_valid && rsp_ready;
    assign load_b = take && (op == OP_WRITE);
    assign load_r = take && (op == OP_READ);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (load_b) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (load_r) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (load_b) bid <= flit_id;
        if (load_r) begin
            rid   <= flit_id;
            rdata <= flit_data;
            rlast <= (kind == KIND_TAIL) || (kind == KIND_SINGLE); // End of burst.
        end
    end

    // Heads only travel on the request side.
    a_no_head: assert property (@(posedge aclk) disable iff (!arst_n)
        rsp_valid |-> kind != KIND_HEAD)
        else $error("depacketizer: head flit on response path");

endmodule

//--- axi2axis_xy.sv
`timescale 1ns/100ps
`include "bridge_settings.svh"

module axi2axis_xy (
    input  logic               aclk,
    input  logic               arst_n,

    output logic               awready,
    input  logic               awvalid,
    input  axi_pkg::axi_id_t   awid,
    input  axi_pkg::axi_addr_t awaddr,
    input  axi_pkg::axi_len_t  awlen,
    input  logic [2:0]         awsize,
    input  logic [1:0]         awburst,

    output logic               wready,
    input  logic               wvalid,
    input  axi_pkg::axi_data_t wdata,
    input  axi_pkg::axi_strb_t wstrb,
    input  logic               wlast,

    output logic               bvalid,
    output axi_pkg::axi_id_t   bid,
    input  logic               bready,

    output logic               arready,
    input  logic               arvalid,
    input  axi_pkg::axi_id_t   arid,
    input  axi_pkg::axi_addr_t araddr,
    input  axi_pkg::axi_len_t  arlen,
    input  logic [2:0]         arsize,
    input  logic [1:0]         arburst,

    output logic               rvalid,
    output axi_pkg::axi_id_t   rid,
    output axi_pkg::axi_data_t rdata,
    output logic               rlast,
    input  logic               rready,

    input  logic               a_tready,
    output logic               a_tvalid,
    output noc_pkg::flit_t     a_tdata,

    output logic               b_tready,
    input  logic               b_tvalid,
    input  noc_pkg::flit_t     b_tdata
);

    import noc_pkg::*;

    logic  req_valid;
    logic  req_ready;
    flit_t req_flit;
    logic  rsp_valid;
    logic  rsp_ready;
    flit_t rsp_flit;

    axi_req_packetizer axi_req_packetizer_i (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .awvalid   (awvalid),
        .awready   (awready),
        .awid      (awid),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awburst   (awburst),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .arvalid   (arvalid),
        .arready   (arready),
        .arid      (arid),
        .araddr    (araddr),
        .arlen     (arlen),
        .arsize    (arsize),
        .arburst   (arburst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_flit  (req_flit)
    );

    // Toward the mesh.
    flit_fifo #(.DEPTH(`REQ_FIFO_DEPTH)) req_fifo_i (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_flit   (req_flit),
        .out_valid (a_tvalid),
        .out_ready (a_tready),
        .out_flit  (a_tdata)
    );

    // From the mesh.
    flit_fifo #(.DEPTH(`RSP_FIFO_DEPTH)) rsp_fifo_i (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .in_valid  (b_tvalid),
        .in_ready  (b_tready),
        .in_flit   (b_tdata),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_flit  (rsp_flit)
    );

    axi_resp_depacketizer axi_resp_depacketizer_i (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_flit  (rsp_flit),
        .bvalid    (bvalid),
        .bid       (bid),
        .bready    (bready),
        .rvalid    (rvalid),
        .rid       (rid),
        .rdata     (rdata),
        .rlast     (rlast),
        .rready    (rready)
    );

endmodule

//--- tb_axi2axis_xy.sv
`timescale 1ns/100ps
`include "bridge_settings.svh"

module tb_axi2axis_xy;

    import axi_pkg::*;
    import noc_pkg::*;

    localparam int N_PAIRS   = 12;
    localparam int MAX_BEATS = 8;

    logic       aclk;
    logic       arst_n;
    logic       awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic       arvalid, arready, rvalid, rlast, rready;
    logic       a_tvalid, a_tready, b_tvalid, b_tready;
    logic [2:0] awsize, arsize;
    logic [1:0] awburst, arburst;
    axi_id_t    awid, bid, arid, rid;
    axi_addr_t  awaddr, araddr;
    axi_len_t   awlen, arlen;
    axi_data_t  wdata, rdata;
    axi_strb_t  wstrb;
    flit_t      a_tdata, b_tdata;

    // One write and one read per pair.
    axi_id_t    w_id   [N_PAIRS];
    axi_addr_t  w_addr [N_PAIRS];
    axi_len_t   w_len  [N_PAIRS];
    axi_data_t  w_data [N_PAIRS][MAX_BEATS];
    axi_strb_t  w_strb [N_PAIRS][MAX_BEATS];
    axi_id_t    r_id   [N_PAIRS];
    axi_addr_t  r_addr [N_PAIRS];
    axi_len_t   r_len  [N_PAIRS];

    flit_t       exp_q[$];
    int          exp_tag[$]; // Write index, or -1 minus read index.
    flit_t       rsp_q[$];
    axi_id_t     exp_b[$];
    logic [36:0] exp_r[$];   // Id, data, last.

    logic [31:0] lfsr;
    int          limit    = 0;
    int          wr_idx   = 0;
    int          rd_idx   = 0;
    int          err_flit = 0;
    int          err_b    = 0;
    int          err_r    = 0;
    int          err_misc = 0;

    axi2axis_xy axi2axis_xy_i (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic axi_data_t ref_rdata(axi_addr_t a, int beat);
        return {a ^ 16'hc3a5, a + 16'(4 * beat)};
    endfunction

    // Expected request flits of one transaction.
    function automatic void push_req_flits(logic is_read, int k);
        axi_addr_t  a;
        axi_len_t   len;
        flit_kind_e kind;
        noc_op_e    op;
        a    = is_read ? r_addr[k] : w_addr[k];
        len  = is_read ? r_len[k] : w_len[k];
        kind = is_read ? KIND_SINGLE : KIND_HEAD;
        op   = is_read ? OP_READ : OP_WRITE;
        exp_q.push_back({kind, op, a[15:14], a[13:12], 2'(`NODE_X), 2'(`NODE_Y),
                         is_read ? r_id[k] : w_id[k], len, a, 1'b0});
        exp_tag.push_back(is_read ? -1 - k : k);
        if (!is_read) begin
            for (int b = 0; b <= int'(len); b++) begin
                kind = (b == int'(len)) ? KIND_TAIL : KIND_BODY;
                exp_q.push_back({kind, w_strb[k][b], w_data[k][b], 2'b00});
                exp_tag.push_back(k);
            end
        end
    endfunction

    // Remote target reply once a request has fully arrived.
    function automatic void answer(int tag);
        int         k;
        flit_kind_e kind;
        axi_data_t  d;
        if (tag >= 0) begin
            rsp_q.push_back({KIND_SINGLE, OP_WRITE, w_id[tag], 32'h0, 1'b0});
            exp_b.push_back(w_id[tag]);
        end else begin
            k = -1 - tag;
            for (int b = 0; b <= int'(r_len[k]); b++) begin
                if (r_len[k] == '0) kind = KIND_SINGLE;
                else kind = (b == int'(r_len[k])) ? KIND_TAIL : KIND_BODY;
                d = ref_rdata(r_addr[k], b);
                rsp_q.push_back({kind, OP_READ, r_id[k], d, 1'b0});
                exp_r.push_back({r_id[k], d, b == int'(r_len[k])});
            end
        end
    endfunction

    // Write addresses back to back. Valid stays high until the last one is taken.
    task automatic drive_aw_stream();
        for (int k = 0; k < N_PAIRS; k++) begin
            @(negedge aclk);
            awvalid = 1'b1;
            awid    = w_id[k];
            awaddr  = w_addr[k];
            awlen   = w_len[k];
            @(posedge aclk);
            while (!awready) @(posedge aclk);
        end
        @(negedge aclk);
        awvalid = 1'b0;
    endtask

    task automatic drive_w_stream();
        for (int k = 0; k < N_PAIRS; k++) begin
            for (int b = 0; b <= int'(w_len[k]); b++) begin
                @(negedge aclk);
                wvalid = 1'b1;
                wdata  = w_data[k][b];
                wstrb  = w_strb[k][b];
                wlast  = (b == int'(w_len[k]));
                @(posedge aclk);
                while (!wready) @(posedge aclk);
            end
        end
        @(negedge aclk);
        wvalid = 1'b0;
        wlast  = 1'b0;
    endtask

    task automatic drive_ar_stream();
        for (int k = 0; k < N_PAIRS; k++) begin
            @(negedge aclk);
            arvalid = 1'b1;
            arid    = r_id[k];
            araddr  = r_addr[k];
            arlen   = r_len[k];
            @(posedge aclk);
            while (!arready) @(posedge aclk);
        end
        @(negedge aclk);
        arvalid = 1'b0;
    endtask

    task automatic check_reset_bit(string name, logic got, logic want);
        assert (got === want) else begin
            err_misc++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic print_counts();
        $display("errors: flit %0d, b %0d, r %0d, other %0d", err_flit, err_b, err_r, err_misc);
    endtask

    // Remote node with stimulus set-up, ready toggling and the flit and beat checks.
    initial begin : remote_node
        flit_t       want;
        logic [36:0] want_r;
        axi_id_t     want_b;
        int          tag;
        int          total;
        logic        last_rd;
        logic        seen_grant;
        lfsr       = 32'hb253;
        total      = 0;
        last_rd    = 1'b0;
        seen_grant = 1'b0;
        for (int k = 0; k < N_PAIRS; k++) begin
            w_id[k]   = axi_id_t'(rand_bits(4));
            w_addr[k] = axi_addr_t'(rand_bits(16)) & 16'hfffc;
            w_len[k]  = (k == 0) ? '0 : axi_len_t'(rand_bits(3)); // First write is single-beat.
            for (int b = 0; b < MAX_BEATS; b++) begin
                w_data[k][b] = rand_bits(32);
                w_strb[k][b] = axi_strb_t'(rand_bits(4));
            end
            r_id[k]   = axi_id_t'(rand_bits(4));
            r_addr[k] = axi_addr_t'(rand_bits(16)) & 16'hfffc;
            r_len[k]  = axi_len_t'(rand_bits(3));
            total += int'(w_len[k]) + 3 + int'(r_len[k]) + 2;
        end
        limit    = 40 * total;
        a_tready = 1'b0;
        bready   = 1'b0;
        rready   = 1'b0;
        b_tvalid = 1'b0;
        b_tdata  = '0;
        wait (arst_n === 1'b1);
        @(posedge aclk);
        check_reset_bit("a_tvalid", a_tvalid, 1'b0);
        check_reset_bit("bvalid", bvalid, 1'b0);
        check_reset_bit("rvalid", rvalid, 1'b0);
        check_reset_bit("b_tready", b_tready, 1'b1);
        forever begin
            @(negedge aclk);
            a_tready = (rand_bits(2) != 0);
            bready   = (rand_bits(2) != 0);
            rready   = (rand_bits(2) != 0);
            b_tvalid = (rsp_q.size() != 0);
            b_tdata  = (rsp_q.size() != 0) ? rsp_q[0] : '0;
            @(posedge aclk);
            if (awvalid && awready) begin
                assert (!(arvalid && seen_grant) || last_rd) else begin
                    err_misc++;
                    $display("error at %0t: AW granted twice in a row while AR waited", $time);
                end
                push_req_flits(1'b0, wr_idx);
                wr_idx++;
                last_rd    = 1'b0;
                seen_grant = 1'b1;
            end
            if (arvalid && arready) begin
                assert (!(awvalid && seen_grant) || !last_rd) else begin
                    err_misc++;
                    $display("error at %0t: AR granted twice in a row while AW waited", $time);
                end
                push_req_flits(1'b1, rd_idx);
                rd_idx++;
                last_rd    = 1'b1;
                seen_grant = 1'b1;
            end
            if (b_tvalid && b_tready) void'(rsp_q.pop_front());
            if (a_tvalid && a_tready) begin
                assert (exp_q.size() != 0) else begin
                    err_misc++;
                    $display("error at %0t: flit on the request stream with none expected", $time);
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    tag  = exp_tag.pop_front();
                    assert (a_tdata === want) else begin
                        err_flit++;
                        $display("error at %0t: a_tdata got %h expected %h", $time, a_tdata, want);
                    end
                    if (want[39:38] == KIND_TAIL || want[39:38] == KIND_SINGLE) answer(tag);
                end
            end
            if (bvalid && bready) begin
                assert (exp_b.size() != 0) else begin
                    err_b++;
                    $display("error at %0t: B beat with no write outstanding", $time);
                end
                if (exp_b.size() != 0) begin
                    want_b = exp_b.pop_front();
                    assert (bid === want_b) else begin
                        err_b++;
                        $display("error at %0t: bid got %h expected %h", $time, bid, want_b);
                    end
                end
            end
            if (rvalid && rready) begin
                assert (exp_r.size() != 0) else begin
                    err_r++;
                    $display("error at %0t: R beat with no read data outstanding", $time);
                end
                if (exp_r.size() != 0) begin
                    want_r = exp_r.pop_front();
                    assert (rid === want_r[36:33]) else begin
                        err_r++;
                        $display("error at %0t: rid got %h expected %h", $time, rid, want_r[36:33]);
                    end
                    assert (rdata === want_r[32:1]) else begin
                        err_r++;
                        $display("error at %0t: rdata got %h expected %h", $time, rdata,
                                 want_r[32:1]);
                    end
                    assert (rlast === want_r[0]) else begin
                        err_r++;
                        $display("error at %0t: rlast got %b expected %b", $time, rlast, want_r[0]);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        @(posedge aclk);
        while (cycles < limit) begin
            @(posedge aclk);
            cycles++;
        end
        $display("timeout: traffic still outstanding after %0d cycles", cycles);
        print_counts();
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        arst_n  = 1'b0;
        awvalid = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awsize  = 3'd2; // 4-byte beats.
        awburst = 2'b01;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        arvalid = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arsize  = 3'd2;
        arburst = 2'b01;
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        arst_n = 1'b1;
        // AW and AR rise together and stay up, so every grant is contested.
        fork
            drive_aw_stream();
            drive_w_stream();
            drive_ar_stream();
        join
        while (wr_idx < N_PAIRS || rd_idx < N_PAIRS || exp_q.size() != 0 ||
               rsp_q.size() != 0 || exp_b.size() != 0 || exp_r.size() != 0) begin
            @(posedge aclk);
        end
        repeat (4) @(posedge aclk);
        print_counts();
        if (err_flit + err_b + err_r + err_misc == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
axi_pkg.sv
noc_pkg.sv
flit_fifo.sv
axi_req_packetizer.sv
axi_resp_depacketizer.sv
axi2axis_xy.sv
tb_axi2axis_xy.sv

//--- Makefile
SRCS := $(filter %.sv,$(shell cat tb.f)) bridge_settings.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_axi2axis_xy: tb.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f tb.f --top-module tb_axi2axis_xy

run: obj_dir/Vtb_axi2axis_xy
	./obj_dir/Vtb_axi2axis_xy | tee sim.log
	grep -q '^\*\*\* TEST PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
